/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = cpu_tb
FILELIST = verilog.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+')
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* dv/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic reset
);
    initial clk = 1'b0;
    always #2 clk = ~clk;   // 4 ns period

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* dv/cpu_props.sv */
`timescale 1ns/1ps
`include "la32_settings.svh"

module cpu_props (
    input logic                       clk,
    input logic                       reset,
    input la32_core_pkg::ctrl_state_t state,
    input la32_isa_pkg::word_t        pc,
    input logic                       data_sram_we,
    input logic                       debug_wb_rf_we,
    input la32_isa_pkg::reg_idx_t     debug_wb_rf_wnum
);
    a_store_in_mem: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> state == la32_core_pkg::st_mem)
        else $error("data write outside the MEM state");

    a_trace_in_wb: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we |-> (state == la32_core_pkg::st_wb && debug_wb_rf_wnum != 5'd0))
        else $error("trace pulse outside WB or aimed at r0");

    // the core comes out of reset ready to fetch from the boot address
    a_reset_state: assert property (@(posedge clk)
        reset |=> (state == la32_core_pkg::st_if && pc == `LA32_RESET_PC))
        else $error("state or pc wrong after reset");

endmodule

bind mycpu_top cpu_props u_props (
    .clk              (clk),
    .reset            (reset),
    .state            (state),
    .pc               (pc),
    .data_sram_we     (data_sram_we),
    .debug_wb_rf_we   (debug_wb_rf_we),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

/* dv/cpu_tb.sv */
`timescale 1ns/1ps
`include "la32_settings.svh"

module cpu_tb;
    localparam int CYCLE_LIMIT = 2000;  // about 5 cycles per instruction over ~300 with margin
    localparam la32_isa_pkg::word_t HALT = {6'h14, 26'd0};  // b to itself

    logic clk, boot_reset, dut_reset;
    logic rst_req = 1'b0;
    la32_isa_pkg::word_t inst_sram_addr, inst_sram_rdata, data_sram_addr, data_sram_wdata;
    la32_isa_pkg::word_t data_sram_rdata, debug_wb_pc, debug_wb_rf_wdata;
    logic data_sram_we, debug_wb_rf_we;
    la32_isa_pkg::reg_idx_t debug_wb_rf_wnum;
    la32_isa_pkg::word_t imem [64];
    la32_isa_pkg::word_t dmem [256];
    la32_isa_pkg::word_t tr_pc[$], tr_data[$], exp_pc[$], exp_data[$];
    la32_isa_pkg::reg_idx_t tr_num[$], exp_num[$];
    int plen;
    int cycles = 0;

    clock_gen u_clk (.clk(clk), .reset(boot_reset));
    assign dut_reset = boot_reset | rst_req;

    mycpu_top DUT (
        .clk(clk), .reset(dut_reset),
        .inst_sram_addr(inst_sram_addr), .inst_sram_rdata(inst_sram_rdata),
        .data_sram_we(data_sram_we), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata), .data_sram_rdata(data_sram_rdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    assign inst_sram_rdata = imem[6'((inst_sram_addr - `LA32_RESET_PC) >> 2)];
    assign data_sram_rdata = dmem[data_sram_addr[9:2]];

    always @(posedge clk) begin
        if (data_sram_we) dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        if (!dut_reset && debug_wb_rf_we) begin
            tr_pc.push_back(debug_wb_pc);
            tr_num.push_back(debug_wb_rf_wnum);
            tr_data.push_back(debug_wb_rf_wdata);
        end
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) abort_run("timeout: the run went past its cycle limit");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input la32_isa_pkg::word_t exp,
                              input la32_isa_pkg::word_t act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_reg(input string name, input la32_isa_pkg::reg_idx_t exp,
                             input la32_isa_pkg::reg_idx_t act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch %s: expected r%0d, actual r%0d", name, exp, act));
        end
    endtask

    function automatic la32_isa_pkg::word_t enc_3r(input logic [16:0] op,
            input la32_isa_pkg::reg_idx_t rd, input la32_isa_pkg::reg_idx_t rj,
            input logic [4:0] rk);
        return {op, rk, rj, rd};    // shifts put ui5 where rk sits
    endfunction

    function automatic la32_isa_pkg::word_t enc_i12(input logic [9:0] op,
            input la32_isa_pkg::reg_idx_t rd, input la32_isa_pkg::reg_idx_t rj,
            input logic [11:0] si12);
        return {op, si12, rj, rd};
    endfunction

    function automatic la32_isa_pkg::word_t enc_br16(input logic [5:0] op,
            input la32_isa_pkg::reg_idx_t rj, input la32_isa_pkg::reg_idx_t rd,
            input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic la32_isa_pkg::word_t enc_b26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic begin_program();
        @(posedge clk);
        rst_req <= 1'b1;
        plen = 0;
        exp_pc.delete();
        exp_num.delete();
        exp_data.delete();
        foreach (imem[i]) imem[i] = HALT;
    endtask

    task automatic put(input la32_isa_pkg::word_t w);
        imem[plen] = w;
        plen++;
    endtask

    // instruction that is expected to write rd with val
    task automatic put_wr(input la32_isa_pkg::word_t w, input la32_isa_pkg::reg_idx_t rd,
                          input la32_isa_pkg::word_t val);
        exp_pc.push_back(`LA32_RESET_PC + 32'(plen) * 4);
        exp_num.push_back(rd);
        exp_data.push_back(val);
        put(w);
    endtask

    task automatic load_const(input la32_isa_pkg::reg_idx_t rd, input la32_isa_pkg::word_t v);
        logic [19:0] hi;
        hi = v[31:12] + 20'(v[11]);     // addi sign-extends the low part
        put_wr({7'h0a, hi, rd}, rd, {hi, 12'h000});
        put_wr(enc_i12(10'h00a, rd, rd, v[11:0]), rd, v);
    endtask

    task automatic release_reset();
        repeat (2) @(posedge clk);
        @(negedge clk);
        tr_pc.delete();
        tr_num.delete();
        tr_data.delete();
        @(posedge clk);
        rst_req <= 1'b0;
    endtask

    task automatic collect_and_compare(input string name);
        while (tr_pc.size() < exp_pc.size()) @(posedge clk);
        repeat (20) @(posedge clk);     // the program now spins on its halt branch
        if (tr_pc.size() != exp_pc.size())
            abort_run($sformatf("%s: %0d write-backs seen where %0d were expected",
                                name, tr_pc.size(), exp_pc.size()));
        foreach (exp_pc[i]) begin
            check_word($sformatf("%s event %0d pc", name, i), exp_pc[i], tr_pc[i]);
            check_reg($sformatf("%s event %0d wnum", name, i), exp_num[i], tr_num[i]);
            check_word($sformatf("%s event %0d wdata", name, i), exp_data[i], tr_data[i]);
        end
    endtask

    task automatic test_reset();
        begin_program();
        put_wr(enc_i12(10'h00a, 5'd1, 5'd0, 12'h123), 5'd1, 32'h123);
        release_reset();
        @(negedge clk);
        check_word("reset fetch address", `LA32_RESET_PC, inst_sram_addr);
        repeat (3) begin   // IF, ID and EXE of the first instruction
            if (data_sram_we || debug_wb_rf_we) abort_run("reset: write or trace pulse too early");
            @(negedge clk);
        end
        collect_and_compare("reset");
    endtask

    task automatic test_reg_alu();
        la32_isa_pkg::word_t a, b;
        a = $urandom() | 32'h8000_0000;     // opposite signs so slt and sltu disagree
        b = $urandom() & 32'h7fff_ffff;
        begin_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        put_wr(enc_3r(17'h00020, 5'd3, 5'd1, 5'd2), 5'd3, a + b);
        put_wr(enc_3r(17'h00022, 5'd4, 5'd1, 5'd2), 5'd4, a - b);
        put_wr(enc_3r(17'h00024, 5'd5, 5'd1, 5'd2), 5'd5, {31'd0, $signed(a) < $signed(b)});
        put_wr(enc_3r(17'h00025, 5'd6, 5'd1, 5'd2), 5'd6, {31'd0, a < b});
        put_wr(enc_3r(17'h00028, 5'd7, 5'd1, 5'd2), 5'd7, ~(a | b));
        put_wr(enc_3r(17'h00029, 5'd8, 5'd1, 5'd2), 5'd8, a & b);
        put_wr(enc_3r(17'h0002a, 5'd9, 5'd1, 5'd2), 5'd9, a | b);
        put_wr(enc_3r(17'h0002b, 5'd10, 5'd1, 5'd2), 5'd10, a ^ b);
        release_reset();
        collect_and_compare("reg_alu");
    endtask

    task automatic test_imm_shift();
        la32_isa_pkg::word_t a;
        logic [4:0] sh;
        logic [11:0] neg;
        a = $urandom() | 32'h8000_0000;     // negative so srai differs from srli
        sh = 5'($urandom_range(31, 1));     // nonzero so every shift moves bits
        neg = {1'b1, 11'($urandom())};
        begin_program();
        load_const(5'd1, a);
        put_wr(enc_3r(17'h00081, 5'd2, 5'd1, sh), 5'd2, a << sh);
        put_wr(enc_3r(17'h00089, 5'd3, 5'd1, sh), 5'd3, a >> sh);
        put_wr(enc_3r(17'h00091, 5'd4, 5'd1, sh), 5'd4, $signed(a) >>> sh);
        put_wr(enc_i12(10'h00a, 5'd5, 5'd1, neg), 5'd5, a + {{20{1'b1}}, neg});
        release_reset();
        collect_and_compare("imm_shift");
    endtask

    task automatic test_memory();
        la32_isa_pkg::word_t d;
        d = $urandom();
        begin_program();
        put_wr(enc_i12(10'h00a, 5'd1, 5'd0, 12'h100), 5'd1, 32'h100);
        load_const(5'd2, d);
        put(enc_i12(10'h0a6, 5'd2, 5'd1, 12'h008));    // st.w r2, r1, 8
        put_wr(enc_i12(10'h0a2, 5'd3, 5'd1, 12'h008), 5'd3, d);
        release_reset();
        collect_and_compare("memory");
        check_word("memory stored word", d, dmem[8'h42]);
    endtask

    task automatic test_control_flow();
        begin_program();
        put_wr(enc_i12(10'h00a, 5'd1, 5'd0, 12'd5), 5'd1, 32'd5);
        put_wr(enc_i12(10'h00a, 5'd2, 5'd0, 12'd5), 5'd2, 32'd5);
        put(enc_br16(6'h16, 5'd1, 5'd2, 16'd2));       // beq taken
        put(enc_i12(10'h00a, 5'd3, 5'd0, 12'd1));
        put(enc_br16(6'h17, 5'd1, 5'd2, 16'd2));       // bne not taken
        put_wr(enc_i12(10'h00a, 5'd4, 5'd0, 12'd7), 5'd4, 32'd7);
        put(enc_b26(6'h14, 26'd2));
        put(enc_i12(10'h00a, 5'd3, 5'd0, 12'd2));
        put_wr(enc_b26(6'h15, 26'd2), 5'd1, `LA32_RESET_PC + 32'd36);
        put(enc_i12(10'h00a, 5'd3, 5'd0, 12'd3));
        put_wr({7'h0a, 20'(`LA32_RESET_PC >> 12), 5'd5}, 5'd5, `LA32_RESET_PC);
        put_wr(enc_br16(6'h13, 5'd5, 5'd6, 16'd13), 5'd6, `LA32_RESET_PC + 32'd48);
        put(enc_i12(10'h00a, 5'd3, 5'd0, 12'd4));
        put(enc_br16(6'h17, 5'd4, 5'd0, 16'd2));       // bne taken
        put(enc_i12(10'h00a, 5'd3, 5'd0, 12'd5));
        put(enc_br16(6'h16, 5'd4, 5'd0, 16'd2));       // beq not taken
        put_wr(enc_i12(10'h00a, 5'd7, 5'd0, 12'd9), 5'd7, 32'd9);
        release_reset();
        collect_and_compare("control_flow");
    endtask

    task automatic test_r0();
        la32_isa_pkg::word_t v;
        v = $urandom();
        begin_program();
        put(enc_i12(10'h00a, 5'd0, 5'd0, 12'h055));
        load_const(5'd1, v);
        put(enc_3r(17'h00020, 5'd0, 5'd1, 5'd1));
        put_wr(enc_3r(17'h00020, 5'd2, 5'd0, 5'd1), 5'd2, v);
        put_wr(enc_3r(17'h00020, 5'd3, 5'd1, 5'd0), 5'd3, v);
        release_reset();
        collect_and_compare("r0");
    endtask

    initial begin
        void'($urandom(32'h31c1_609d));
        foreach (dmem[i]) dmem[i] = 32'hd00d_0000 ^ (32'(i) * 32'h0001_0003);
        foreach (imem[i]) imem[i] = HALT;
        test_reset();
        test_reg_alu();
        test_imm_shift();
        test_memory();
        test_control_flow();
        test_r0();
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* include/la32_settings.svh */
`ifndef LA32_SETTINGS_SVH
`define LA32_SETTINGS_SVH

// first fetch address out of reset
`define LA32_RESET_PC 32'h1c00_0000

// architectural general purpose registers, r0 included
`define LA32_NUM_REGS 32

`define LA32_XLEN 32    // data, address and instruction width

`endif

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
    input  la32_isa_pkg::alu_op_t alu_op,
    input  la32_isa_pkg::word_t   src1,
    input  la32_isa_pkg::word_t   src2,
    output la32_isa_pkg::word_t   result
);
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = src2[4:0];     // only the low five bits count for .w shifts
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (alu_op)
            la32_isa_pkg::alu_add:  result = src1 + src2;
            la32_isa_pkg::alu_sub:  result = src1 - src2;
            la32_isa_pkg::alu_slt:  result = {31'b0, lt_signed};
            la32_isa_pkg::alu_sltu: result = {31'b0, lt_unsigned};
            la32_isa_pkg::alu_and:  result = src1 & src2;
            la32_isa_pkg::alu_nor:  result = ~(src1 | src2);
            la32_isa_pkg::alu_or:   result = src1 | src2;
            la32_isa_pkg::alu_xor:  result = src1 ^ src2;
            la32_isa_pkg::alu_sll:  result = src1 << shamt;
            la32_isa_pkg::alu_srl:  result = src1 >> shamt;
            la32_isa_pkg::alu_sra:  result = $signed(src1) >>> shamt;
            la32_isa_pkg::alu_lui:  result = src2;
            default:                result = src1 + src2;
        endcase
    end

endmodule

/* logic/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  la32_isa_pkg::word_t     inst,
    output la32_isa_pkg::alu_op_t   alu_op,
    output la32_core_pkg::br_kind_t br_kind,
    output la32_isa_pkg::reg_idx_t  rj,
    output la32_isa_pkg::reg_idx_t  rk_or_rd,
    output la32_isa_pkg::reg_idx_t  dest,
    output la32_isa_pkg::word_t     imm,
    output la32_isa_pkg::word_t     br_offs,
    output la32_isa_pkg::word_t     jirl_offs,
    output logic                    src1_is_pc,
    output logic                    src2_is_imm,
    output logic                    is_load,
    output logic                    is_store,
    output logic                    reg_write
);
    logic [63:0] op_31_26_d;
    logic [15:0] op_25_22_d;
    logic [3:0]  op_21_20_d;
    logic [31:0] op_19_15_d;
    la32_isa_pkg::reg_idx_t rd, rk;
    la32_isa_pkg::ui5_t     ui5;
    la32_isa_pkg::si12_t    si12;
    la32_isa_pkg::si16_t    si16;
    la32_isa_pkg::si20_t    si20;
    la32_isa_pkg::si26_t    si26;
    logic grp_3r, grp_sh;
    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w, inst_ld_w, inst_st_w;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne, inst_lu12i_w;
    logic need_ui5, need_si20, need_si26, src2_is_4, writes_rd;

    // one-hot field decodes
    assign op_31_26_d = 64'd1 << inst[31:26];
    assign op_25_22_d = 16'd1 << inst[25:22];
    assign op_21_20_d = 4'd1 << inst[21:20];
    assign op_19_15_d = 32'd1 << inst[19:15];

    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];
    assign ui5  = inst[14:10];
    assign si12 = inst[21:10];
    assign si16 = inst[25:10];
    assign si20 = inst[24:5];
    assign si26 = {inst[9:0], inst[25:10]};     // offs[25:16] sits in the low bits

    assign grp_3r = op_31_26_d[6'h00] & op_25_22_d[4'h0] & op_21_20_d[2'h1];
    assign grp_sh = op_31_26_d[6'h00] & op_25_22_d[4'h1] & op_21_20_d[2'h0];

    assign inst_add_w   = grp_3r & op_19_15_d[5'h00];
    assign inst_sub_w   = grp_3r & op_19_15_d[5'h02];
    assign inst_slt     = grp_3r & op_19_15_d[5'h04];
    assign inst_sltu    = grp_3r & op_19_15_d[5'h05];
    assign inst_nor     = grp_3r & op_19_15_d[5'h08];
    assign inst_and     = grp_3r & op_19_15_d[5'h09];
    assign inst_or      = grp_3r & op_19_15_d[5'h0a];
    assign inst_xor     = grp_3r & op_19_15_d[5'h0b];
    assign inst_slli_w  = grp_sh & op_19_15_d[5'h01];
    assign inst_srli_w  = grp_sh & op_19_15_d[5'h09];
    assign inst_srai_w  = grp_sh & op_19_15_d[5'h11];
    assign inst_addi_w  = op_31_26_d[6'h00] & op_25_22_d[4'ha];
    assign inst_ld_w    = op_31_26_d[6'h0a] & op_25_22_d[4'h2];
    assign inst_st_w    = op_31_26_d[6'h0a] & op_25_22_d[4'h6];
    assign inst_jirl    = op_31_26_d[6'h13];
    assign inst_b       = op_31_26_d[6'h14];
    assign inst_bl      = op_31_26_d[6'h15];
    assign inst_beq     = op_31_26_d[6'h16];
    assign inst_bne     = op_31_26_d[6'h17];
    assign inst_lu12i_w = op_31_26_d[6'h05] & ~inst[25];

    always_comb begin
        case (1'b1)
            inst_sub_w:   alu_op = la32_isa_pkg::alu_sub;
            inst_slt:     alu_op = la32_isa_pkg::alu_slt;
            inst_sltu:    alu_op = la32_isa_pkg::alu_sltu;
            inst_and:     alu_op = la32_isa_pkg::alu_and;
            inst_nor:     alu_op = la32_isa_pkg::alu_nor;
            inst_or:      alu_op = la32_isa_pkg::alu_or;
            inst_xor:     alu_op = la32_isa_pkg::alu_xor;
            inst_slli_w:  alu_op = la32_isa_pkg::alu_sll;
            inst_srli_w:  alu_op = la32_isa_pkg::alu_srl;
            inst_srai_w:  alu_op = la32_isa_pkg::alu_sra;
            inst_lu12i_w: alu_op = la32_isa_pkg::alu_lui;
            default:      alu_op = la32_isa_pkg::alu_add;   // addresses and link values too
        endcase
    end

    always_comb begin
        case (1'b1)
            inst_b:    br_kind = la32_core_pkg::br_b;
            inst_bl:   br_kind = la32_core_pkg::br_bl;
            inst_beq:  br_kind = la32_core_pkg::br_beq;
            inst_bne:  br_kind = la32_core_pkg::br_bne;
            inst_jirl: br_kind = la32_core_pkg::br_jirl;
            default:   br_kind = la32_core_pkg::br_none;
        endcase
    end

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si20 = inst_lu12i_w;
    assign need_si26 = inst_b | inst_bl;
    assign src2_is_4 = inst_jirl | inst_bl;     // link value is pc+4 through the ALU

    assign imm = src2_is_4 ? 32'd4 :
                 need_si20 ? {si20, 12'b0} :
                 need_ui5  ? {27'b0, ui5} :
                             {{20{si12[11]}}, si12};
    assign br_offs   = need_si26 ? {{4{si26[25]}}, si26, 2'b0} : {{14{si16[15]}}, si16, 2'b0};
    assign jirl_offs = {{14{si16[15]}}, si16, 2'b0};

    assign rk_or_rd    = (inst_beq | inst_bne | inst_st_w) ? rd : rk;
    assign src1_is_pc  = inst_jirl | inst_bl;
    assign src2_is_imm = need_ui5 | inst_addi_w | inst_ld_w | inst_st_w | inst_lu12i_w
                       | src2_is_4;
    assign is_load  = inst_ld_w;
    assign is_store = inst_st_w;
    assign dest     = inst_bl ? 5'd1 : rd;

    // unknown encodings fall out here and run as a no-op
    assign writes_rd = grp_3r & (inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor
                     | inst_and | inst_or | inst_xor)
                     | need_ui5 | inst_addi_w | inst_ld_w | inst_lu12i_w | src2_is_4;
    assign reg_write = writes_rd & (dest != 5'd0);

endmodule

/* logic/la32_core_pkg.sv */
package la32_core_pkg;

    // one state per phase of the multicycle sequence
    typedef enum logic [2:0] {
        st_if,
        st_id,
        st_exe,
        st_mem,
        st_wb
    } ctrl_state_t;

    // what the branch unit does with the instruction in EXE
    typedef enum logic [2:0] {
        br_none,
        br_b,
        br_bl,      // also links pc+4 into r1
        br_beq,
        br_bne,
        br_jirl     // target is rj plus offset and the link goes into rd
    } br_kind_t;

endpackage

/* logic/la32_isa_pkg.sv */
`include "la32_settings.svh"

package la32_isa_pkg;

    typedef logic [`LA32_XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // raw immediate fields as they sit in the instruction word
    typedef logic [4:0]  ui5_t;     // shift amount of the immediate shifts
    typedef logic [11:0] si12_t;    // addi.w, ld.w, st.w
    typedef logic [15:0] si16_t;    // beq, bne, jirl
    typedef logic [19:0] si20_t;    // lu12i.w
    typedef logic [25:0] si26_t;    // b, bl, split over two places in the word

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui     // result is src2 since the decoder builds the shifted si20
    } alu_op_t;

endpackage

/* logic/mycpu_top.sv */
`timescale 1ns/1ps
`include "la32_settings.svh"

module mycpu_top (
    input  logic                   clk,
    input  logic                   reset,
    output la32_isa_pkg::word_t    inst_sram_addr,
    input  la32_isa_pkg::word_t    inst_sram_rdata,
    output logic                   data_sram_we,
    output la32_isa_pkg::word_t    data_sram_addr,
    output la32_isa_pkg::word_t    data_sram_wdata,
    input  la32_isa_pkg::word_t    data_sram_rdata,
    output la32_isa_pkg::word_t    debug_wb_pc,
    output logic                   debug_wb_rf_we,
    output la32_isa_pkg::reg_idx_t debug_wb_rf_wnum,
    output la32_isa_pkg::word_t    debug_wb_rf_wdata
);
    la32_core_pkg::ctrl_state_t state, next_state;
    la32_isa_pkg::word_t pc, npc, inst;
    la32_isa_pkg::word_t rj_value, rkd_value, alu_result_q, mem_result;
    la32_isa_pkg::alu_op_t alu_op;
    la32_core_pkg::br_kind_t br_kind;
    la32_isa_pkg::reg_idx_t rj, rk_or_rd, dest;
    la32_isa_pkg::word_t imm, br_offs, jirl_offs;
    logic src1_is_pc, src2_is_imm, is_load, is_store, reg_write;
    la32_isa_pkg::word_t rf_rdata1, rf_rdata2, rf_wdata;
    la32_isa_pkg::word_t alu_src1, alu_src2, alu_result;
    la32_isa_pkg::word_t br_target, exe_next_pc;
    logic br_taken, rf_we;

    inst_decoder u_dec (
        .inst        (inst),
        .alu_op      (alu_op),
        .br_kind     (br_kind),
        .rj          (rj),
        .rk_or_rd    (rk_or_rd),
        .dest        (dest),
        .imm         (imm),
        .br_offs     (br_offs),
        .jirl_offs   (jirl_offs),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .is_load     (is_load),
        .is_store    (is_store),
        .reg_write   (reg_write)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .rdata1 (rf_rdata1),
        .raddr2 (rk_or_rd),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (dest),
        .wdata  (rf_wdata)
    );

    assign alu_src1 = src1_is_pc ? pc : rj_value;
    assign alu_src2 = src2_is_imm ? imm : rkd_value;

    alu u_alu (
        .alu_op (alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    // branches resolve here and the result only matters in EXE
    always_comb begin
        case (br_kind)
            la32_core_pkg::br_b,
            la32_core_pkg::br_bl,
            la32_core_pkg::br_jirl: br_taken = 1'b1;
            la32_core_pkg::br_beq:  br_taken = (rj_value == rkd_value);
            la32_core_pkg::br_bne:  br_taken = (rj_value != rkd_value);
            default:                br_taken = 1'b0;
        endcase
    end
    assign br_target   = (br_kind == la32_core_pkg::br_jirl) ? rj_value + jirl_offs : pc + br_offs;
    assign exe_next_pc = br_taken ? br_target : pc + 32'd4;

    always_comb begin
        case (state)
            la32_core_pkg::st_if:  next_state = la32_core_pkg::st_id;
            la32_core_pkg::st_id:  next_state = la32_core_pkg::st_exe;
            la32_core_pkg::st_exe: begin
                if (is_load || is_store) begin
                    next_state = la32_core_pkg::st_mem;
                end else if (br_kind == la32_core_pkg::br_b || br_kind == la32_core_pkg::br_beq
                             || br_kind == la32_core_pkg::br_bne) begin
                    next_state = la32_core_pkg::st_if;  // nothing to write back
                end else begin
                    next_state = la32_core_pkg::st_wb;
                end
            end
            la32_core_pkg::st_mem: begin
                next_state = is_load ? la32_core_pkg::st_wb : la32_core_pkg::st_if;
            end
            default:               next_state = la32_core_pkg::st_if;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= la32_core_pkg::st_if;
            pc           <= `LA32_RESET_PC;
            data_sram_we <= 1'b0;
        end else begin
            state        <= next_state;
            data_sram_we <= (state == la32_core_pkg::st_exe) && is_store;  // high through MEM only
            // pc holds the current instruction until the next fetch so the trace sees it in WB
            if (next_state == la32_core_pkg::st_if) begin
                pc <= (state == la32_core_pkg::st_exe) ? exe_next_pc : npc;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            la32_core_pkg::st_if:  inst <= inst_sram_rdata;
            la32_core_pkg::st_id: begin
                rj_value  <= rf_rdata1;
                rkd_value <= rf_rdata2;
            end
            la32_core_pkg::st_exe: begin
                alu_result_q    <= alu_result;
                npc             <= exe_next_pc;
                data_sram_addr  <= alu_result;
                data_sram_wdata <= rkd_value;
            end
            la32_core_pkg::st_mem: mem_result <= data_sram_rdata;
            default: begin
            end
        endcase
    end

    assign inst_sram_addr = pc;
    assign rf_we    = (state == la32_core_pkg::st_wb) && reg_write;  // reg_write already excludes r0
    assign rf_wdata = is_load ? mem_result : alu_result_q;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

/* logic/regfile.sv */
`timescale 1ns/1ps
`include "la32_settings.svh"

module regfile (
    input  logic                   clk,
    input  la32_isa_pkg::reg_idx_t raddr1,
    output la32_isa_pkg::word_t    rdata1,
    input  la32_isa_pkg::reg_idx_t raddr2,
    output la32_isa_pkg::word_t    rdata2,
    input  logic                   we,
    input  la32_isa_pkg::reg_idx_t waddr,
    input  la32_isa_pkg::word_t    wdata
);
    la32_isa_pkg::word_t regs [`LA32_NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired so its storage is never written or read
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

/* verilog.f */
+incdir+include
logic/la32_isa_pkg.sv
logic/la32_core_pkg.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/alu.sv
logic/mycpu_top.sv
dv/clock_gen.sv
dv/cpu_props.sv
dv/cpu_tb.sv
